// ==== include/ialu_cfg.svh ====
// --------------------
// Width and geometry constants for the pipelined ALU
// and its square-root stages
// --------------------

`ifndef IALU_CFG_SVH
`define IALU_CFG_SVH

// Datapath
`define IALU_XLEN           32      // Operand and result width
`define IALU_SHAMT_W        5       // Shift amount taken from op2

// Square root
`define IALU_ROOT_W         16      // Root of a 32-bit radicand
`define IALU_ROOT_STAGES    4       // Pipeline stages for the root
`define IALU_ROOT_BITS      4       // Root bits resolved in one stage

`endif // IALU_CFG_SVH

// ==== rtl/ialu_pkg.sv ====
// --------------------
// ALU types: command encoding, compare flags,
// request word and pipeline flow word
// --------------------

`default_nettype none

`include "ialu_cfg.svh"

package ialu_pkg;

    // --------------------
    // Commands
    // --------------------
    typedef enum logic [3:0] {
        IALU_CMD_ADD  = 4'd0,
        IALU_CMD_SUB  = 4'd1,
        IALU_CMD_AND  = 4'd2,
        IALU_CMD_OR   = 4'd3,
        IALU_CMD_XOR  = 4'd4,
        IALU_CMD_SLT  = 4'd5,       // Signed less-than
        IALU_CMD_SLTU = 4'd6,       // Unsigned less-than
        IALU_CMD_EQ   = 4'd7,
        IALU_CMD_NE   = 4'd8,
        IALU_CMD_GE   = 4'd9,       // Signed greater-or-equal
        IALU_CMD_GEU  = 4'd10,      // Unsigned greater-or-equal
        IALU_CMD_SLL  = 4'd11,
        IALU_CMD_SRL  = 4'd12,
        IALU_CMD_SRA  = 4'd13,
        IALU_CMD_SQRT = 4'd14       // Floor of sqrt(op1)
    } ialu_cmd_e;

    // Flags of op1 - op2
    typedef struct packed {
        logic z;                    // Zero
        logic s;                    // Sign
        logic o;                    // Signed overflow
        logic c;                    // Borrow out
    } ialu_flags_s;

    // Operation as it enters the unit
    typedef struct packed {
        ialu_cmd_e              cmd;
        logic [`IALU_XLEN-1:0]  op1;
        logic [`IALU_XLEN-1:0]  op2;
    } ialu_req_s;

    // Word carried from stage to stage
    typedef struct packed {
        logic                    vd;        // Slot holds an operation
        logic                    is_root;   // Retire takes the root
        logic [`IALU_XLEN-1:0]   alu_res;   // Single-cycle result
        logic                    cmp;       // Compare outcome
        logic [`IALU_XLEN-1:0]   radicand;
        logic [`IALU_ROOT_W-1:0] root;      // Partial root, MSBs first
    } ialu_flow_s;

endpackage : ialu_pkg

`default_nettype wire

// ==== rtl/ialu_issue.sv ====
// --------------------
// Issue stage: command decode, adder with flags,
// logic ops, shifter, compares, first flow register
// --------------------

`default_nettype none

`include "ialu_cfg.svh"

module ialu_issue (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_vd,
    input  ialu_pkg::ialu_req_s in_req,
    output ialu_pkg::ialu_flow_s flow_o
);

    logic                      sum_sub;     // Subtract for all but ADD
    logic [`IALU_XLEN:0]       sum_res;     // Result with borrow/carry bit
    ialu_pkg::ialu_flags_s     flags;
    logic [`IALU_SHAMT_W-1:0]  shamt;
    logic [`IALU_XLEN-1:0]     alu_res;
    logic                      cmp;
    logic                      vd_q;
    ialu_pkg::ialu_flow_s      data_q;

    // --------------------
    // Adder and flags
    // --------------------
    always_comb begin
        sum_sub = (in_req.cmd != ialu_pkg::IALU_CMD_ADD);
        if (sum_sub) begin
            sum_res = {1'b0, in_req.op1} - {1'b0, in_req.op2};
        end else begin
            sum_res = {1'b0, in_req.op1} + {1'b0, in_req.op2};
        end

        flags.c = sum_res[`IALU_XLEN];                 // Set when op1 < op2 unsigned
        flags.z = ~|sum_res[`IALU_XLEN-1:0];
        flags.s = sum_res[`IALU_XLEN-1];
        flags.o = (~in_req.op1[`IALU_XLEN-1] &  in_req.op2[`IALU_XLEN-1] &  flags.s) |
                  ( in_req.op1[`IALU_XLEN-1] & ~in_req.op2[`IALU_XLEN-1] & ~flags.s);
    end

    assign shamt = in_req.op2[`IALU_SHAMT_W-1:0];

    // --------------------
    // Result select
    // --------------------
    always_comb begin
        alu_res = '0;
        cmp     = 1'b0;
        case (in_req.cmd)
            ialu_pkg::IALU_CMD_ADD,
            ialu_pkg::IALU_CMD_SUB:  alu_res = sum_res[`IALU_XLEN-1:0];
            ialu_pkg::IALU_CMD_AND:  alu_res = in_req.op1 & in_req.op2;
            ialu_pkg::IALU_CMD_OR:   alu_res = in_req.op1 | in_req.op2;
            ialu_pkg::IALU_CMD_XOR:  alu_res = in_req.op1 ^ in_req.op2;
            ialu_pkg::IALU_CMD_SLT:  cmp = flags.s ^ flags.o;
            ialu_pkg::IALU_CMD_SLTU: cmp = flags.c;
            ialu_pkg::IALU_CMD_EQ:   cmp = flags.z;
            ialu_pkg::IALU_CMD_NE:   cmp = ~flags.z;
            ialu_pkg::IALU_CMD_GE:   cmp = ~(flags.s ^ flags.o);
            ialu_pkg::IALU_CMD_GEU:  cmp = ~flags.c;
            ialu_pkg::IALU_CMD_SLL:  alu_res = in_req.op1 << shamt;
            ialu_pkg::IALU_CMD_SRL:  alu_res = in_req.op1 >> shamt;
            ialu_pkg::IALU_CMD_SRA:  alu_res = $signed(in_req.op1) >>> shamt;   // Sign fill
            default: begin
            end
        endcase

        // The six compares return their flag zero-extended
        if (cmp) begin
            alu_res = {{(`IALU_XLEN-1){1'b0}}, 1'b1};
        end
    end

    // --------------------
    // Flow word 0
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vd_q <= 1'b0;
        end else begin
            vd_q <= in_vd;
        end
    end

    always_ff @(posedge clk) begin
        data_q.vd       <= in_vd;
        data_q.is_root  <= (in_req.cmd == ialu_pkg::IALU_CMD_SQRT);
        data_q.alu_res  <= alu_res;
        data_q.cmp      <= cmp;
        data_q.radicand <= in_req.op1;
        data_q.root     <= '0;                         // Root stages fill it in
    end

    always_comb begin
        flow_o    = data_q;
        flow_o.vd = vd_q;                              // Only the reset copy of vd leaves
    end

endmodule : ialu_issue

`default_nettype wire

// ==== rtl/isqrt_stage.sv ====
// --------------------
// Square-root stage: resolves IALU_ROOT_BITS root bits
// and registers the flow word
// --------------------

`default_nettype none

`include "ialu_cfg.svh"

module isqrt_stage #(
    parameter int unsigned STAGE_IDX = 0       // 0 resolves the top bits
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ialu_pkg::ialu_flow_s flow_i,
    output ialu_pkg::ialu_flow_s flow_o
);

    // Highest root bit handled here
    localparam int unsigned TOP_BIT = `IALU_ROOT_W - 1 - STAGE_IDX * `IALU_ROOT_BITS;

    logic [`IALU_ROOT_W-1:0] root_nxt;
    logic                    vd_q;
    ialu_pkg::ialu_flow_s    data_q;

    // --------------------
    // Bit resolution
    // --------------------
    // Each bit is tried in turn from the top and kept when the trial
    // root squared still fits under the radicand.
    always_comb begin : resolve
        logic [`IALU_ROOT_W-1:0]   trial;
        logic [2*`IALU_ROOT_W-1:0] square;

        root_nxt = flow_i.root;
        for (int i = 0; i < `IALU_ROOT_BITS; i++) begin
            trial  = root_nxt | (`IALU_ROOT_W'(1) << (TOP_BIT - i));
            square = trial * trial;                    // Full 32-bit product
            if (square <= flow_i.radicand) begin
                root_nxt = trial;                      // Keep the bit
            end
        end
    end

    // --------------------
    // Flow register
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vd_q <= 1'b0;
        end else begin
            vd_q <= flow_i.vd;
        end
    end

    always_ff @(posedge clk) begin
        data_q      <= flow_i;                         // Other fields ride along
        data_q.root <= root_nxt;
    end

    always_comb begin
        flow_o    = data_q;
        flow_o.vd = vd_q;
    end

endmodule : isqrt_stage

`default_nettype wire

// ==== rtl/ialu_retire.sv ====
// --------------------
// Retire stage: picks root or ALU result
// and registers the unit outputs
// --------------------

`default_nettype none

`include "ialu_cfg.svh"

module ialu_retire (
    input  logic                  clk,
    input  logic                  rst_n,
    input  ialu_pkg::ialu_flow_s  flow_i,
    output logic                  out_vd,
    output logic [`IALU_XLEN-1:0] out_res,
    output logic                  out_cmp
);

    logic [`IALU_XLEN-1:0] res_sel;

    // Root is zero-extended to the data width
    assign res_sel = flow_i.is_root ?
                     {{(`IALU_XLEN-`IALU_ROOT_W){1'b0}}, flow_i.root} :
                     flow_i.alu_res;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_vd  <= 1'b0;
            out_cmp <= 1'b0;
        end else begin
            out_vd  <= flow_i.vd;
            out_cmp <= flow_i.vd & flow_i.cmp;         // Low on bubbles
        end
    end

    always_ff @(posedge clk) begin
        out_res <= res_sel;
    end

endmodule : ialu_retire

`default_nettype wire

// ==== rtl/ialu_top.sv ====
// --------------------
// Pipelined integer ALU: issue, square-root stages
// and retire, fixed 5-cycle latency
// --------------------

`default_nettype none

`include "ialu_cfg.svh"

module ialu_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_vd,      // One strobe per operation
    input  ialu_pkg::ialu_req_s   in_req,
    output logic                  out_vd,     // One strobe per result
    output logic [`IALU_XLEN-1:0] out_res,
    output logic                  out_cmp
);

    // Flow word i feeds root stage i, the last one feeds retire
    ialu_pkg::ialu_flow_s flow [0:`IALU_ROOT_STAGES];

    // --------------------
    // Issue
    // --------------------
    ialu_issue u_issue (
        .clk    (clk),
        .rst_n  (rst_n),
        .in_vd  (in_vd),
        .in_req (in_req),
        .flow_o (flow[0])
    );

    // --------------------
    // Root stages
    // --------------------
    for (genvar i = 0; i < `IALU_ROOT_STAGES; i++) begin : g_root
        isqrt_stage #(
            .STAGE_IDX (i)
        ) u_stage (
            .clk    (clk),
            .rst_n  (rst_n),
            .flow_i (flow[i]),
            .flow_o (flow[i+1])
        );
    end

    // --------------------
    // Retire
    // --------------------
    ialu_retire u_retire (
        .clk     (clk),
        .rst_n   (rst_n),
        .flow_i  (flow[`IALU_ROOT_STAGES]),
        .out_vd  (out_vd),
        .out_res (out_res),
        .out_cmp (out_cmp)
    );

endmodule : ialu_top

`default_nettype wire

// ==== verif/ialu_clkgen.sv ====
// --------------------
// Testbench clock and power-on reset
// --------------------

`default_nettype none

module ialu_clkgen #(
    parameter int unsigned PERIOD_NS  = 4,
    parameter int unsigned RST_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;                  // Released on an edge, seen at the next
    end

endmodule : ialu_clkgen

`default_nettype wire

// ==== verif/ialu_props.sv ====
// --------------------
// Concurrent checks on result strobe latency
// and compare gating of the ALU pipeline
// --------------------

`default_nettype none

module ialu_props (
    input logic clk,
    input logic rst_n,
    input logic in_vd,
    input logic out_vd,
    input logic out_cmp
);
    timeunit 1ns;
    timeprecision 100ps;

    // in_vd is taken at edge k and out_vd is set at edge k+5,
    // so the sampled strobe trails the sampled input by six edges
    localparam int unsigned VD_DELAY = 6;

    a_latency : assert property (@(posedge clk) disable iff (!rst_n)
        out_vd == $past(in_vd, VD_DELAY))
        else $error("out_vd does not follow in_vd by the pipeline latency");

    a_cmp_gated : assert property (@(posedge clk) disable iff (!rst_n)
        !out_vd |-> !out_cmp)
        else $error("out_cmp is high without a result strobe");

endmodule : ialu_props

bind ialu_top ialu_props props_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_vd   (in_vd),
    .out_vd  (out_vd),
    .out_cmp (out_cmp)
);

`default_nettype wire

// ==== verif/ialu_tb.sv ====
// --------------------
// ALU testbench: directed and random operation table,
// behavioral model, scoreboard and watchdog
// --------------------

`default_nettype none

`include "ialu_cfg.svh"

module ialu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned CLK_PERIOD_NS = 4;
    localparam int unsigned RST_CYCLES    = 8;
    localparam int unsigned DRAIN_CYCLES  = 10;    // Latency plus margin
    localparam int unsigned RAND_ROWS     = 48;

    typedef struct packed {
        logic [`IALU_XLEN-1:0] res;
        logic                  cmp;
    } result_s;

    typedef struct packed {
        logic                vd;                   // Low for a bubble
        ialu_pkg::ialu_req_s req;
        result_s             exp;
    } row_s;

    logic                  clk;
    logic                  rst_n;
    logic                  in_vd;
    ialu_pkg::ialu_req_s   in_req;
    logic                  out_vd;
    logic [`IALU_XLEN-1:0] out_res;
    logic                  out_cmp;

    row_s                  table_q[$];
    result_s               exp_q[$];           // Results still in flight
    logic [31:0]           rng_state;

    ialu_clkgen #(
        .PERIOD_NS  (CLK_PERIOD_NS),
        .RST_CYCLES (RST_CYCLES)
    ) clkgen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ialu_top dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_vd   (in_vd),
        .in_req  (in_req),
        .out_vd  (out_vd),
        .out_res (out_res),
        .out_cmp (out_cmp)
    );

    // --------------------
    // Reference model
    // --------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [`IALU_XLEN-1:0] floor_sqrt(input logic [`IALU_XLEN-1:0] v);
        logic [63:0] r;
        logic [63:0] wide_v;
        wide_v = {{(64-`IALU_XLEN){1'b0}}, v};
        r = 64'($rtoi($sqrt(real'(v))));
        // Trim any rounding of the floating-point estimate
        while (r * r > wide_v) r = r - 64'd1;
        while ((r + 64'd1) * (r + 64'd1) <= wide_v) r = r + 64'd1;
        return r[`IALU_XLEN-1:0];
    endfunction

    function automatic result_s expected_result(input ialu_pkg::ialu_req_s req);
        result_s                      r;
        logic [`IALU_SHAMT_W-1:0]     sh;
        logic signed [`IALU_XLEN-1:0] a;
        logic signed [`IALU_XLEN-1:0] b;
        r  = '0;
        sh = req.op2[`IALU_SHAMT_W-1:0];
        a  = req.op1;
        b  = req.op2;
        case (req.cmd)
            ialu_pkg::IALU_CMD_ADD:  r.res = req.op1 + req.op2;
            ialu_pkg::IALU_CMD_SUB:  r.res = req.op1 - req.op2;
            ialu_pkg::IALU_CMD_AND:  r.res = req.op1 & req.op2;
            ialu_pkg::IALU_CMD_OR:   r.res = req.op1 | req.op2;
            ialu_pkg::IALU_CMD_XOR:  r.res = req.op1 ^ req.op2;
            ialu_pkg::IALU_CMD_SLT:  r.cmp = (a < b);
            ialu_pkg::IALU_CMD_SLTU: r.cmp = (req.op1 < req.op2);
            ialu_pkg::IALU_CMD_EQ:   r.cmp = (req.op1 == req.op2);
            ialu_pkg::IALU_CMD_NE:   r.cmp = (req.op1 != req.op2);
            ialu_pkg::IALU_CMD_GE:   r.cmp = (a >= b);
            ialu_pkg::IALU_CMD_GEU:  r.cmp = (req.op1 >= req.op2);
            ialu_pkg::IALU_CMD_SLL:  r.res = req.op1 << sh;
            ialu_pkg::IALU_CMD_SRL:  r.res = req.op1 >> sh;
            ialu_pkg::IALU_CMD_SRA:  r.res = (req.op1 >> sh) |
                (req.op1[`IALU_XLEN-1] ? ~({`IALU_XLEN{1'b1}} >> sh) : '0);
            ialu_pkg::IALU_CMD_SQRT: r.res = floor_sqrt(req.op1);
            default: ;
        endcase
        if (r.cmp) r.res = `IALU_XLEN'(1);             // Compare flag as a word
        return r;
    endfunction

    // --------------------
    // Failure reporting and checks
    // --------------------
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_res(input logic [`IALU_XLEN-1:0] got,
                             input logic [`IALU_XLEN-1:0] expd);
        if (got !== expd)
            report_failure($sformatf("CHECK FAILED out_res: got 0x%08h, expected 0x%08h",
                                     got, expd));
    endtask

    task automatic check_cmp(input logic got, input logic expd);
        if (got !== expd)
            report_failure($sformatf("CHECK FAILED out_cmp: got 0x%0h, expected 0x%0h",
                                     got, expd));
    endtask

    // --------------------
    // Operation table
    // --------------------
    task automatic push_row(input logic vd, input ialu_pkg::ialu_req_s req,
                            input result_s exp);
        row_s row;
        row.vd  = vd;
        row.req = req;
        row.exp = exp;
        table_q.push_back(row);
    endtask

    task automatic add_op(input ialu_pkg::ialu_cmd_e cmd, input logic [31:0] op1,
                          input logic [31:0] op2, input logic [31:0] res, input logic cmp);
        ialu_pkg::ialu_req_s req;
        result_s             exp;
        req.cmd = cmd;
        req.op1 = op1;
        req.op2 = op2;
        exp.res = res;
        exp.cmp = cmp;
        push_row(1'b1, req, exp);
    endtask

    task automatic add_bubble();
        push_row(1'b0, '0, '0);
    endtask

    task automatic build_directed();
        add_op(ialu_pkg::IALU_CMD_ADD,  32'h00000001, 32'h00000002, 32'h00000003, 1'b0);
        add_op(ialu_pkg::IALU_CMD_ADD,  32'hFFFFFFFF, 32'h00000001, 32'h00000000, 1'b0);
        add_op(ialu_pkg::IALU_CMD_ADD,  32'h7FFFFFFF, 32'h00000001, 32'h80000000, 1'b0);
        add_op(ialu_pkg::IALU_CMD_SUB,  32'h00000005, 32'h00000007, 32'hFFFFFFFE, 1'b0);
        add_op(ialu_pkg::IALU_CMD_SUB,  32'h80000000, 32'h00000001, 32'h7FFFFFFF, 1'b0);
        add_op(ialu_pkg::IALU_CMD_AND,  32'hF0F0F0F0, 32'hFF00FF00, 32'hF000F000, 1'b0);
        add_op(ialu_pkg::IALU_CMD_OR,   32'hF0F0F0F0, 32'h0F0F0000, 32'hFFFFF0F0, 1'b0);
        add_op(ialu_pkg::IALU_CMD_XOR,  32'hAAAA5555, 32'hFFFF0000, 32'h55555555, 1'b0);
        add_bubble();
        add_op(ialu_pkg::IALU_CMD_SLT,  32'h80000000, 32'h00000001, 32'h00000001, 1'b1);
        add_op(ialu_pkg::IALU_CMD_SLT,  32'h00000001, 32'h80000000, 32'h00000000, 1'b0);
        add_op(ialu_pkg::IALU_CMD_SLT,  32'hFFFFFFFF, 32'h00000000, 32'h00000001, 1'b1);
        add_op(ialu_pkg::IALU_CMD_SLTU, 32'h80000000, 32'h00000001, 32'h00000000, 1'b0);
        add_op(ialu_pkg::IALU_CMD_SLTU, 32'h00000001, 32'h80000000, 32'h00000001, 1'b1);
        add_op(ialu_pkg::IALU_CMD_EQ,   32'h12345678, 32'h12345678, 32'h00000001, 1'b1);
        add_op(ialu_pkg::IALU_CMD_EQ,   32'h12345678, 32'h12345679, 32'h00000000, 1'b0);
        add_op(ialu_pkg::IALU_CMD_NE,   32'h00000000, 32'h00000001, 32'h00000001, 1'b1);
        add_op(ialu_pkg::IALU_CMD_NE,   32'h00000005, 32'h00000005, 32'h00000000, 1'b0);
        add_op(ialu_pkg::IALU_CMD_GE,   32'h80000000, 32'h00000001, 32'h00000000, 1'b0);
        add_op(ialu_pkg::IALU_CMD_GE,   32'h7FFFFFFF, 32'h80000000, 32'h00000001, 1'b1);
        add_op(ialu_pkg::IALU_CMD_GE,   32'hFFFFFFFF, 32'h00000000, 32'h00000000, 1'b0);
        add_op(ialu_pkg::IALU_CMD_GEU,  32'h80000000, 32'h00000001, 32'h00000001, 1'b1);
        add_op(ialu_pkg::IALU_CMD_GEU,  32'h00000001, 32'h00000002, 32'h00000000, 1'b0);
        add_bubble();
        add_bubble();
        add_op(ialu_pkg::IALU_CMD_SLL,  32'h00000001, 32'h0000001F, 32'h80000000, 1'b0);
        add_op(ialu_pkg::IALU_CMD_SLL,  32'h12345678, 32'h00000024, 32'h23456780, 1'b0);
        add_op(ialu_pkg::IALU_CMD_SRL,  32'h80000000, 32'h0000001F, 32'h00000001, 1'b0);
        add_op(ialu_pkg::IALU_CMD_SRL,  32'hF0000000, 32'h00000104, 32'h0F000000, 1'b0);
        add_op(ialu_pkg::IALU_CMD_SRA,  32'h80000000, 32'h00000004, 32'hF8000000, 1'b0);
        add_op(ialu_pkg::IALU_CMD_SRA,  32'h7FFFFFFF, 32'h0000001E, 32'h00000001, 1'b0);
        add_op(ialu_pkg::IALU_CMD_SRA,  32'hF0000000, 32'h0000003F, 32'hFFFFFFFF, 1'b0);
        // Root ignores op2
        add_op(ialu_pkg::IALU_CMD_SQRT, 32'h00000000, 32'hDEADBEEF, 32'h00000000, 1'b0);
        add_op(ialu_pkg::IALU_CMD_SQRT, 32'h00000001, 32'h00000000, 32'h00000001, 1'b0);
        add_op(ialu_pkg::IALU_CMD_SQRT, 32'h00000002, 32'h00000000, 32'h00000001, 1'b0);
        add_op(ialu_pkg::IALU_CMD_SQRT, 32'h0000000F, 32'h00000000, 32'h00000003, 1'b0);
        add_op(ialu_pkg::IALU_CMD_SQRT, 32'h00000010, 32'h00000000, 32'h00000004, 1'b0);
        add_op(ialu_pkg::IALU_CMD_SQRT, 32'h00010000, 32'h00000000, 32'h00000100, 1'b0);
        add_op(ialu_pkg::IALU_CMD_SQRT, 32'h40000000, 32'h00000000, 32'h00008000, 1'b0);
        add_op(ialu_pkg::IALU_CMD_SQRT, 32'hFFFE0000, 32'h00000000, 32'h0000FFFE, 1'b0);
        add_op(ialu_pkg::IALU_CMD_SQRT, 32'hFFFE0001, 32'h00000000, 32'h0000FFFF, 1'b0);
        add_op(ialu_pkg::IALU_CMD_SQRT, 32'hFFFFFFFF, 32'h00000000, 32'h0000FFFF, 1'b0);
    endtask

    task automatic build_random();
        ialu_pkg::ialu_req_s req;
        logic [31:0]         sel;
        for (int n = 0; n < RAND_ROWS; n++) begin
            rng_state = xorshift32(rng_state);
            sel       = rng_state;
            rng_state = xorshift32(rng_state);
            req.op1   = rng_state;
            rng_state = xorshift32(rng_state);
            req.op2   = rng_state;
            req.cmd   = ialu_pkg::ialu_cmd_e'(4'(sel[31:4] % 28'd15));
            if (n % 4 == 0) req.cmd = ialu_pkg::IALU_CMD_SQRT;
            if (sel[5:4] == 2'd0) req.op2 = req.op1;  // Equal operands
            if (sel[3:0] == 4'd0) begin
                add_bubble();
            end else begin
                push_row(1'b1, req, expected_result(req));
            end
        end
    endtask

    // --------------------
    // Stimulus
    // --------------------
    initial begin : stimulus
        in_vd     = 1'b0;
        in_req    = '0;
        rng_state = 32'd52;
        build_directed();
        build_random();
        @(posedge rst_n);
        foreach (table_q[i]) begin
            @(posedge clk);
            in_vd  <= table_q[i].vd;
            in_req <= table_q[i].req;
            if (table_q[i].vd) exp_q.push_back(table_q[i].exp);
        end
        @(posedge clk);
        in_vd  <= 1'b0;
        in_req <= '0;
        for (int w = 0; w < DRAIN_CYCLES && exp_q.size() != 0; w++) @(posedge clk);
        if (exp_q.size() == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            report_failure($sformatf("%0d results never came out", exp_q.size()));
        end
    end

    // Scoreboard, sampled mid-cycle
    always @(negedge clk) begin : monitor
        result_s expd;
        if (out_vd) begin
            if (exp_q.size() == 0) begin
                report_failure("Result strobe seen with no operation in flight");
            end else begin
                expd = exp_q.pop_front();
                check_res(out_res, expd.res);
                check_cmp(out_cmp, expd.cmp);
            end
        end
    end

    initial begin : watchdog
        int unsigned limit_ns;
        @(posedge rst_n);
        limit_ns = (table_q.size() + 20) * CLK_PERIOD_NS;
        #(limit_ns);
        report_failure("Watchdog expired before all results were checked");
    end

endmodule : ialu_tb

`default_nettype wire

// ==== ialu.f ====
+incdir+include
rtl/ialu_pkg.sv
rtl/ialu_issue.sv
rtl/isqrt_stage.sv
rtl/ialu_retire.sv
rtl/ialu_top.sv
verif/ialu_clkgen.sv
verif/ialu_props.sv
verif/ialu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the ALU testbench with Verilator and runs it.
# A failing check ends the run with $fatal, so the exit status fails the script.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    -f ialu.f --top-module ialu_tb -o ialu_sim

./obj_dir/ialu_sim
